// File: source/ccc_pkg.sv
// CCC handler shared definitions
`default_nettype none

package ccc_pkg;

  typedef logic [7:0]  ccc_code_t;
  typedef logic [6:0]  addr7_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] len16_t;
  typedef logic [47:0] pid_t;

  localparam addr7_t RsvdAddr = 7'h7E;

  // Broadcast codes
  localparam ccc_code_t CccBcastEnec   = 8'h00;
  localparam ccc_code_t CccBcastDisec  = 8'h01;
  localparam ccc_code_t CccBcastRstdaa = 8'h06;
  localparam ccc_code_t CccBcastSetmwl = 8'h09;
  localparam ccc_code_t CccBcastSetmrl = 8'h0A;

  // Direct codes, bit 7 set
  localparam ccc_code_t CccDirectEnec      = 8'h80;
  localparam ccc_code_t CccDirectDisec     = 8'h81;
  localparam ccc_code_t CccDirectSetnewda  = 8'h88;
  localparam ccc_code_t CccDirectSetmwl    = 8'h89;
  localparam ccc_code_t CccDirectSetmrl    = 8'h8A;
  localparam ccc_code_t CccDirectGetmwl    = 8'h8B;
  localparam ccc_code_t CccDirectGetmrl    = 8'h8C;
  localparam ccc_code_t CccDirectGetpid    = 8'h8D;
  localparam ccc_code_t CccDirectGetbcr    = 8'h8E;
  localparam ccc_code_t CccDirectGetdcr    = 8'h8F;
  localparam ccc_code_t CccDirectGetstatus = 8'h90;

  typedef struct packed {
    logic rstart;
    logic stop;
  } bus_cond_t;

  typedef struct packed {
    byte_t data;
    logic  done;
  } bus_rx_t;

  typedef struct packed {
    logic req_bit;
    logic req_byte;
  } bus_rx_req_t;

  typedef struct packed {
    logic  req_byte;
    logic  req_bit;
    byte_t value;
    logic  sel_od_pp;
  } bus_tx_req_t;

  typedef struct packed {
    addr7_t sta_addr;
    logic   sta_valid;
    addr7_t dyn_addr;
    logic   dyn_valid;
  } target_addr_t;

  typedef struct packed {
    logic ibi;
    logic crr;
    logic hj;
  } ev_flags_t;

  typedef enum logic [3:0] {
    Idle,
    WaitCcc,
    RxTbit,
    RxByte,
    RxByteTbit,
    RxDirectAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    WaitBusCond,
    NextCcc,
    DoneCcc
  } ccc_state_e;

endpackage

`default_nettype wire

// File: source/ccc_ctrl.sv
// CCC control FSM
`timescale 1ns/1ps
`default_nettype none

module ccc_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ccc_pkg::ccc_code_t   ccc_i,
  input  logic                 ccc_valid_i,
  input  ccc_pkg::bus_cond_t   bus_cond_i,
  input  logic                 rx_done_i,
  input  logic                 tx_done_i,
  input  logic                 addr_ack_i,
  input  logic                 addr_rsvd_i,
  input  logic                 addr_ours_i,
  input  logic                 addr_rnw_i,
  input  ccc_pkg::byte_t       tx_byte_i,
  input  logic                 tx_last_i,
  output ccc_pkg::ccc_state_e  state_o,
  output ccc_pkg::ccc_code_t   code_o,
  output ccc_pkg::bus_rx_req_t rx_req_o,
  output ccc_pkg::bus_tx_req_t tx_req_o,
  output logic                 done_fsm_o,
  output logic                 next_ccc_o
);
  import ccc_pkg::*;

  ccc_state_e state_q;
  ccc_state_e state_d;
  ccc_code_t  code_q;
  logic       is_direct;

  assign is_direct = code_q[7];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q <= '0;
    end else if (state_q == WaitCcc && ccc_valid_i) begin
      code_q <= ccc_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:    state_d = WaitCcc;
      WaitCcc: if (ccc_valid_i) state_d = RxTbit;
      RxTbit: begin
        if (rx_done_i) begin
          if (is_direct) state_d = RxByte;
          else if (code_q == CccBcastRstdaa) state_d = WaitBusCond;
          else state_d = RxData;
        end
      end
      // Sr here starts the address phase of a direct CCC
      RxByte: begin
        if (bus_cond_i.rstart) state_d = RxDirectAddr;
        else if (rx_done_i) state_d = RxByteTbit;
      end
      RxByteTbit:   if (rx_done_i) state_d = RxByte;
      RxDirectAddr: if (rx_done_i) state_d = TxAddrAck;
      TxAddrAck: begin
        if (tx_done_i) begin
          if (addr_rsvd_i) state_d = NextCcc;
          else if (addr_ours_i && addr_rnw_i) state_d = TxData;
          else if (addr_ours_i) state_d = RxData;
          else state_d = WaitBusCond;
        end
      end
      RxData: begin
        if (bus_cond_i.rstart) state_d = RxDirectAddr;
        else if (rx_done_i) state_d = RxDataTbit;
      end
      RxDataTbit: if (rx_done_i) state_d = RxData;
      TxData: begin
        if (bus_cond_i.rstart) state_d = RxDirectAddr;
        else if (tx_done_i) state_d = TxDataTbit;
      end
      TxDataTbit: begin
        if (bus_cond_i.rstart) state_d = RxDirectAddr;
        else if (tx_done_i) state_d = tx_last_i ? WaitBusCond : TxData;
      end
      WaitBusCond: if (bus_cond_i.rstart) state_d = RxDirectAddr;
      // Reserved address hands control back for another CCC
      NextCcc: state_d = WaitCcc;
      DoneCcc: state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  // STOP ends any CCC
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (bus_cond_i.stop) begin
      state_q <= DoneCcc;
    end else begin
      state_q <= state_d;
    end
  end

  // Request levels per state
  always_comb begin
    rx_req_o = '0;
    tx_req_o = '0;
    case (state_q)
      RxTbit, RxByteTbit, RxDataTbit: rx_req_o.req_bit = 1'b1;
      RxByte, RxDirectAddr, RxData:   rx_req_o.req_byte = 1'b1;
      TxAddrAck: begin
        // ACK is low, sent open drain
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = {7'd0, ~addr_ack_i};
      end
      TxData: begin
        tx_req_o.req_byte  = 1'b1;
        tx_req_o.value     = tx_byte_i;
        tx_req_o.sel_od_pp = 1'b1;
      end
      TxDataTbit: begin
        tx_req_o.req_bit   = 1'b1;
        tx_req_o.value     = {7'd0, ~tx_last_i};
        tx_req_o.sel_od_pp = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign state_o    = state_q;
  assign code_o     = code_q;
  assign done_fsm_o = (state_q == DoneCcc);
  assign next_ccc_o = (state_q == NextCcc);

endmodule

`default_nettype wire

// File: source/ccc_addr_match.sv
// Direct CCC address match
`timescale 1ns/1ps
`default_nettype none

module ccc_addr_match (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ccc_pkg::ccc_state_e   state_i,
  input  ccc_pkg::bus_rx_t      rx_i,
  input  ccc_pkg::target_addr_t target_i,
  output logic                  ack_o,
  output logic                  rsvd_o,
  output logic                  ours_o,
  output logic                  rnw_o,
  output logic                  ours_dyn_o
);
  import ccc_pkg::*;

  addr7_t addr_q;
  logic   rnw_q;
  logic   valid_q;
  logic   sta_hit;
  logic   dyn_hit;

  // Address is only meaningful until the next CCC begins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q  <= '0;
      rnw_q   <= 1'b0;
      valid_q <= 1'b0;
    end else if (state_i == RxDirectAddr && rx_i.done) begin
      addr_q  <= rx_i.data[7:1];
      rnw_q   <= rx_i.data[0];
      valid_q <= 1'b1;
    end else if (state_i == WaitCcc) begin
      valid_q <= 1'b0;
    end
  end

  assign sta_hit = target_i.sta_valid && (addr_q == target_i.sta_addr);
  assign dyn_hit = target_i.dyn_valid && (addr_q == target_i.dyn_addr);

  assign rsvd_o     = valid_q && (addr_q == RsvdAddr);
  assign ours_o     = valid_q && (sta_hit || dyn_hit);
  assign ours_dyn_o = valid_q && dyn_hit;
  assign ack_o      = rsvd_o || ours_o;
  assign rnw_o      = rnw_q;

endmodule

`default_nettype wire

// File: source/ccc_get_tx.sv
// Direct GET transmit datapath
`timescale 1ns/1ps
`default_nettype none

module ccc_get_tx #(
  parameter ccc_pkg::byte_t IbiPayload = 8'hFF
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ccc_pkg::ccc_state_e state_i,
  input  ccc_pkg::ccc_code_t  code_i,
  input  logic                tx_done_i,
  input  ccc_pkg::byte_t      get_bcr_i,
  input  ccc_pkg::byte_t      get_dcr_i,
  input  ccc_pkg::len16_t     get_mwl_i,
  input  ccc_pkg::len16_t     get_mrl_i,
  input  ccc_pkg::pid_t       get_pid_i,
  input  ccc_pkg::len16_t     get_status_i,
  output ccc_pkg::byte_t      tx_byte_o,
  output logic                tx_last_o
);
  import ccc_pkg::*;

  logic [2:0] cnt_q;
  logic [2:0] cnt_init;

  // Bytes to send per GET
  always_comb begin
    case (code_i)
      CccDirectGetbcr, CccDirectGetdcr:    cnt_init = 3'd1;
      CccDirectGetmwl, CccDirectGetstatus: cnt_init = 3'd2;
      CccDirectGetmrl:                     cnt_init = 3'd3;
      CccDirectGetpid:                     cnt_init = 3'd6;
      default:                             cnt_init = 3'd0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (state_i == TxAddrAck) begin
      cnt_q <= cnt_init;
    end else if (state_i == TxData && tx_done_i && cnt_q != 3'd0) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

  // Count reaches zero once the final byte is out
  assign tx_last_o = (cnt_q == 3'd0);

  // Highest count holds the most significant byte
  always_comb begin
    tx_byte_o = '0;
    case (code_i)
      CccDirectGetbcr:    tx_byte_o = get_bcr_i;
      CccDirectGetdcr:    tx_byte_o = get_dcr_i;
      CccDirectGetmwl:    tx_byte_o = (cnt_q == 3'd2) ? get_mwl_i[15:8] : get_mwl_i[7:0];
      CccDirectGetstatus: tx_byte_o = (cnt_q == 3'd2) ? get_status_i[15:8] : get_status_i[7:0];
      CccDirectGetmrl: begin
        if (cnt_q == 3'd3) tx_byte_o = get_mrl_i[15:8];
        else if (cnt_q == 3'd2) tx_byte_o = get_mrl_i[7:0];
        else tx_byte_o = IbiPayload;
      end
      CccDirectGetpid: begin
        case (cnt_q)
          3'd6:    tx_byte_o = get_pid_i[47:40];
          3'd5:    tx_byte_o = get_pid_i[39:32];
          3'd4:    tx_byte_o = get_pid_i[31:24];
          3'd3:    tx_byte_o = get_pid_i[23:16];
          3'd2:    tx_byte_o = get_pid_i[15:8];
          default: tx_byte_o = get_pid_i[7:0];
        endcase
      end
      default: tx_byte_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/ccc_set_rx.sv
// SET CCC receive datapath
`timescale 1ns/1ps
`default_nettype none

module ccc_set_rx (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ccc_pkg::ccc_state_e state_i,
  input  ccc_pkg::ccc_code_t  code_i,
  input  ccc_pkg::bus_rx_t    rx_i,
  input  logic                ccc_valid_i,
  input  logic                addr_rsvd_i,
  input  logic                addr_ours_dyn_i,
  output logic                set_mwl_o,
  output ccc_pkg::len16_t     mwl_o,
  output logic                set_mrl_o,
  output ccc_pkg::len16_t     mrl_o,
  output ccc_pkg::ev_flags_t  enec_o,
  output ccc_pkg::ev_flags_t  disec_o,
  output logic                rstdaa_o,
  output logic                set_newda_o,
  output ccc_pkg::addr7_t     newda_o
);
  import ccc_pkg::*;

  byte_t      data_q;
  logic [1:0] cnt_q;
  logic       tbit_done;
  logic       newda_hit;
  ev_flags_t  ev_byte;

  assign tbit_done = (state_i == RxDataTbit) && rx_i.done && !addr_rsvd_i;
  assign newda_hit = tbit_done && (code_i == CccDirectSetnewda) && (cnt_q == 2'd0) &&
                     addr_ours_dyn_i;
  assign ev_byte   = '{ibi: data_q[0], crr: data_q[1], hj: data_q[3]};

  always_ff @(posedge clk_i) begin
    if (state_i == RxData && rx_i.done) data_q <= rx_i.data;
    if (newda_hit) newda_o <= data_q[7:1];
  end

  // Data byte index, saturates past the longest SET
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (ccc_valid_i || (state_i == RxDirectAddr && rx_i.done)) begin
      cnt_q <= '0;
    end else if (state_i == RxDataTbit && rx_i.done && cnt_q != 2'd3) begin
      cnt_q <= cnt_q + 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_mwl_o   <= 1'b0;
      mwl_o       <= '0;
      set_mrl_o   <= 1'b0;
      mrl_o       <= '0;
      enec_o      <= '0;
      disec_o     <= '0;
      rstdaa_o    <= 1'b0;
      set_newda_o <= 1'b0;
    end else begin
      set_mwl_o   <= 1'b0;
      set_mrl_o   <= 1'b0;
      set_newda_o <= newda_hit;
      rstdaa_o    <= (state_i == RxTbit) && rx_i.done && (code_i == CccBcastRstdaa);
      if (tbit_done) begin
        case (code_i)
          // High byte first, pulse once the low byte lands
          CccBcastSetmwl, CccDirectSetmwl: begin
            if (cnt_q == 2'd0) mwl_o[15:8] <= data_q;
            if (cnt_q == 2'd1) begin
              mwl_o[7:0] <= data_q;
              set_mwl_o  <= 1'b1;
            end
          end
          CccBcastSetmrl, CccDirectSetmrl: begin
            if (cnt_q == 2'd0) mrl_o[15:8] <= data_q;
            if (cnt_q == 2'd1) begin
              mrl_o[7:0] <= data_q;
              set_mrl_o  <= 1'b1;
            end
          end
          CccBcastEnec, CccDirectEnec:   if (cnt_q == 2'd0) enec_o <= ev_byte;
          CccBcastDisec, CccDirectDisec: if (cnt_q == 2'd0) disec_o <= ev_byte;
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: source/ccc_top.sv
// CCC handler top level
`timescale 1ns/1ps
`default_nettype none

module ccc_top #(
  parameter ccc_pkg::byte_t IbiPayload = 8'hFF
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ccc_pkg::ccc_code_t    ccc_i,
  input  logic                  ccc_valid_i,
  input  ccc_pkg::bus_cond_t    bus_cond_i,
  input  ccc_pkg::bus_rx_t      bus_rx_i,
  input  logic                  tx_done_i,
  output ccc_pkg::bus_rx_req_t  rx_req_o,
  output ccc_pkg::bus_tx_req_t  tx_req_o,
  output logic                  done_fsm_o,
  output logic                  next_ccc_o,
  input  ccc_pkg::target_addr_t target_i,
  input  ccc_pkg::byte_t        get_bcr_i,
  input  ccc_pkg::byte_t        get_dcr_i,
  input  ccc_pkg::len16_t       get_mwl_i,
  input  ccc_pkg::len16_t       get_mrl_i,
  input  ccc_pkg::pid_t         get_pid_i,
  input  ccc_pkg::len16_t       get_status_i,
  output logic                  set_mwl_o,
  output ccc_pkg::len16_t       mwl_o,
  output logic                  set_mrl_o,
  output ccc_pkg::len16_t       mrl_o,
  output ccc_pkg::ev_flags_t    enec_o,
  output ccc_pkg::ev_flags_t    disec_o,
  output logic                  rstdaa_o,
  output logic                  set_newda_o,
  output ccc_pkg::addr7_t       newda_o
);
  import ccc_pkg::*;

  ccc_state_e state;
  ccc_code_t  code;
  byte_t      tx_byte;
  logic       tx_last;
  logic       addr_ack;
  logic       addr_rsvd;
  logic       addr_ours;
  logic       addr_rnw;
  logic       addr_ours_dyn;

  ccc_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .ccc_i,
    .ccc_valid_i,
    .bus_cond_i,
    .rx_done_i   (bus_rx_i.done),
    .tx_done_i,
    .addr_ack_i  (addr_ack),
    .addr_rsvd_i (addr_rsvd),
    .addr_ours_i (addr_ours),
    .addr_rnw_i  (addr_rnw),
    .tx_byte_i   (tx_byte),
    .tx_last_i   (tx_last),
    .state_o     (state),
    .code_o      (code),
    .rx_req_o,
    .tx_req_o,
    .done_fsm_o,
    .next_ccc_o
  );

  ccc_addr_match u_addr_match (
    .clk_i,
    .rst_ni,
    .state_i    (state),
    .rx_i       (bus_rx_i),
    .target_i,
    .ack_o      (addr_ack),
    .rsvd_o     (addr_rsvd),
    .ours_o     (addr_ours),
    .rnw_o      (addr_rnw),
    .ours_dyn_o (addr_ours_dyn)
  );

  ccc_get_tx #(
    .IbiPayload (IbiPayload)
  ) u_get_tx (
    .clk_i,
    .rst_ni,
    .state_i   (state),
    .code_i    (code),
    .tx_done_i,
    .get_bcr_i,
    .get_dcr_i,
    .get_mwl_i,
    .get_mrl_i,
    .get_pid_i,
    .get_status_i,
    .tx_byte_o (tx_byte),
    .tx_last_o (tx_last)
  );

  ccc_set_rx u_set_rx (
    .clk_i,
    .rst_ni,
    .state_i         (state),
    .code_i          (code),
    .rx_i            (bus_rx_i),
    .ccc_valid_i,
    .addr_rsvd_i     (addr_rsvd),
    .addr_ours_dyn_i (addr_ours_dyn),
    .set_mwl_o,
    .mwl_o,
    .set_mrl_o,
    .mrl_o,
    .enec_o,
    .disec_o,
    .rstdaa_o,
    .set_newda_o,
    .newda_o
  );

endmodule

`default_nettype wire

// File: dv/ccc_chk.sv
// CCC bus request checks
`timescale 1ns/1ps
`default_nettype none

module ccc_chk (
  input logic                 clk_i,
  input logic                 rst_ni,
  input ccc_pkg::bus_rx_req_t rx_req_i,
  input ccc_pkg::bus_tx_req_t tx_req_i,
  input logic                 done_fsm_i
);

  logic rx_any;
  logic tx_any;

  assign rx_any = rx_req_i.req_bit || rx_req_i.req_byte;
  assign tx_any = tx_req_i.req_bit || tx_req_i.req_byte;

  // Receiver and transmitter never requested together
  req_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni) !(rx_any && tx_any))
    else $error("rx and tx requests active in the same cycle");

  // One request kind per direction
  rx_kind_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rx_req_i.req_bit && rx_req_i.req_byte))
    else $error("rx bit and byte requested together");

  tx_kind_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tx_req_i.req_bit && tx_req_i.req_byte))
    else $error("tx bit and byte requested together");

  // Done is a single cycle strobe
  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_fsm_i |=> !done_fsm_i)
    else $error("done_fsm_o high for more than one cycle");

endmodule

`default_nettype wire

// File: dv/tb_ccc.sv
// CCC handler testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ccc;
  import ccc_pkg::*;

  localparam byte_t      IbiPayload = 8'h5C;
  localparam addr7_t     StaAddr    = 7'h2A;
  localparam addr7_t     DynAddr    = 7'h31;
  localparam addr7_t     OtherAddr  = 7'h15;
  localparam int         NumCcc     = 200;
  localparam int         Timeout    = 64;
  localparam logic [3:0] ReqRxBit   = 4'b1000;
  localparam logic [3:0] ReqRxByte  = 4'b0100;
  localparam logic [3:0] ReqTxByte  = 4'b0010;
  localparam logic [3:0] ReqTxBit   = 4'b0001;

  logic         clk = 1'b0;
  logic         rst_n;
  ccc_code_t    ccc;
  logic         ccc_valid;
  bus_cond_t    bus_cond;
  bus_rx_t      bus_rx;
  logic         tx_done;
  bus_rx_req_t  rx_req;
  bus_tx_req_t  tx_req;
  logic         done_fsm;
  logic         next_ccc;
  target_addr_t target;
  byte_t        get_bcr;
  byte_t        get_dcr;
  len16_t       get_mwl;
  len16_t       get_mrl;
  pid_t         get_pid;
  len16_t       get_status;
  logic         set_mwl;
  len16_t       mwl;
  logic         set_mrl;
  len16_t       mrl;
  ev_flags_t    enec;
  ev_flags_t    disec;
  logic         rstdaa;
  logic         set_newda;
  addr7_t       newda;
  logic [3:0]   bus_req;

  // Reference model
  integer    seed = 32'h5a10;
  len16_t    exp_mwl = '0;
  len16_t    exp_mrl = '0;
  ev_flags_t exp_enec = '0;
  ev_flags_t exp_disec = '0;
  addr7_t    exp_newda = '0;
  addr7_t    seen_newda = '0;
  // Pulse counts: set_mwl, set_mrl, rstdaa, set_newda, next_ccc, done_fsm
  int        seen [6];
  int        want [6];

  ccc_code_t codes [16] = '{
    CccBcastEnec, CccBcastDisec, CccBcastRstdaa, CccBcastSetmwl, CccBcastSetmrl,
    CccDirectEnec, CccDirectDisec, CccDirectSetnewda, CccDirectSetmwl, CccDirectSetmrl,
    CccDirectGetmwl, CccDirectGetmrl, CccDirectGetpid, CccDirectGetbcr, CccDirectGetdcr,
    CccDirectGetstatus
  };

  always #50 clk = ~clk;

  ccc_top #(
    .IbiPayload (IbiPayload)
  ) dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .ccc_i        (ccc),
    .ccc_valid_i  (ccc_valid),
    .bus_cond_i   (bus_cond),
    .bus_rx_i     (bus_rx),
    .tx_done_i    (tx_done),
    .rx_req_o     (rx_req),
    .tx_req_o     (tx_req),
    .done_fsm_o   (done_fsm),
    .next_ccc_o   (next_ccc),
    .target_i     (target),
    .get_bcr_i    (get_bcr),
    .get_dcr_i    (get_dcr),
    .get_mwl_i    (get_mwl),
    .get_mrl_i    (get_mrl),
    .get_pid_i    (get_pid),
    .get_status_i (get_status),
    .set_mwl_o    (set_mwl),
    .mwl_o        (mwl),
    .set_mrl_o    (set_mrl),
    .mrl_o        (mrl),
    .enec_o       (enec),
    .disec_o      (disec),
    .rstdaa_o     (rstdaa),
    .set_newda_o  (set_newda),
    .newda_o      (newda)
  );

  bind ccc_top ccc_chk u_chk (
    .clk_i,
    .rst_ni,
    .rx_req_i   (rx_req_o),
    .tx_req_i   (tx_req_o),
    .done_fsm_i (done_fsm_o)
  );

  assign bus_req = {rx_req.req_bit, rx_req.req_byte, tx_req.req_byte, tx_req.req_bit};

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic byte_t rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // ENEC and DISEC byte layout
  function automatic ev_flags_t event_bits(input byte_t b);
    ev_flags_t ev;
    ev.ibi = b[0];
    ev.crr = b[1];
    ev.hj  = b[3];
    return ev;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic expect_equal(input string name, input logic [47:0] got,
                              input logic [47:0] exp);
    assert (got === exp)
      else abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Wait for any bus request, then check its kind
  task automatic wait_request(input logic [3:0] kind);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (bus_req == 4'd0) begin
      if (cycles == Timeout) abort_run("timed out waiting for a bus request from the DUT");
      cycles++;
      @(negedge clk);
    end
    expect_equal("bus request", 48'(bus_req), 48'(kind));
  endtask

  task automatic bus_delay();
    repeat (1 + rand_below(4)) @(posedge clk);
  endtask

  task automatic serve_rx(input logic [3:0] kind, input byte_t value);
    wait_request(kind);
    bus_delay();
    bus_rx <= '{data: value, done: 1'b1};
    @(posedge clk);
    bus_rx.done <= 1'b0;
  endtask

  task automatic serve_tx(input logic [3:0] kind, input byte_t value, input logic pp);
    wait_request(kind);
    expect_equal("tx_req_o.value", 48'(tx_req.value), 48'(value));
    expect_equal("tx_req_o.sel_od_pp", 48'(tx_req.sel_od_pp), 48'(pp));
    bus_delay();
    tx_done <= 1'b1;
    @(posedge clk);
    tx_done <= 1'b0;
  endtask

  // Sr in place of the next direct byte
  task automatic send_rstart();
    wait_request(ReqRxByte);
    bus_delay();
    bus_cond.rstart <= 1'b1;
    @(posedge clk);
    bus_cond.rstart <= 1'b0;
  endtask

  task automatic send_ccc(input ccc_code_t code);
    @(posedge clk);
    ccc       <= code;
    ccc_valid <= 1'b1;
    @(posedge clk);
    ccc_valid <= 1'b0;
  endtask

  task automatic compare_outputs();
    expect_equal("mwl_o", 48'(mwl), 48'(exp_mwl));
    expect_equal("mrl_o", 48'(mrl), 48'(exp_mrl));
    expect_equal("enec_o", 48'(enec), 48'(exp_enec));
    expect_equal("disec_o", 48'(disec), 48'(exp_disec));
    expect_equal("newda_o", 48'(seen_newda), 48'(exp_newda));
    expect_equal("set_mwl_o pulses", 48'(seen[0]), 48'(want[0]));
    expect_equal("set_mrl_o pulses", 48'(seen[1]), 48'(want[1]));
    expect_equal("rstdaa_o pulses", 48'(seen[2]), 48'(want[2]));
    expect_equal("set_newda_o pulses", 48'(seen[3]), 48'(want[3]));
    expect_equal("next_ccc_o pulses", 48'(seen[4]), 48'(want[4]));
    expect_equal("done_fsm_o pulses", 48'(seen[5]), 48'(want[5]));
  endtask

  // STOP, done strobe lands in the following cycle
  task automatic end_ccc();
    @(posedge clk);
    bus_cond.stop <= 1'b1;
    @(negedge clk);
    expect_equal("done_fsm_o", 48'(done_fsm), 48'd0);
    @(posedge clk);
    bus_cond.stop <= 1'b0;
    @(negedge clk);
    expect_equal("done_fsm_o", 48'(done_fsm), 48'd1);
    @(negedge clk);
    expect_equal("done_fsm_o", 48'(done_fsm), 48'd0);
    want[5]++;
    compare_outputs();
  endtask

  task automatic write_data(input ccc_code_t code, input logic dyn_hit);
    byte_t first;
    byte_t second;
    logic  is_mwl;
    logic  is_mrl;
    is_mwl = (code == CccBcastSetmwl) || (code == CccDirectSetmwl);
    is_mrl = (code == CccBcastSetmrl) || (code == CccDirectSetmrl);
    first  = rand_byte();
    second = rand_byte();
    serve_rx(ReqRxByte, first);
    serve_rx(ReqRxBit, 8'h00);
    if (is_mwl || is_mrl) begin
      serve_rx(ReqRxByte, second);
      serve_rx(ReqRxBit, 8'h00);
    end
    if (is_mwl) begin
      exp_mwl = {first, second};
      want[0]++;
    end else if (is_mrl) begin
      exp_mrl = {first, second};
      want[1]++;
    end else if (code == CccBcastEnec || code == CccDirectEnec) begin
      exp_enec = event_bits(first);
    end else if (code == CccBcastDisec || code == CccDirectDisec) begin
      exp_disec = event_bits(first);
    end else if (code == CccDirectSetnewda && dyn_hit) begin
      exp_newda = first[7:1];
      want[3]++;
    end
  endtask

  task automatic read_data(input ccc_code_t code);
    pid_t value;
    pid_t shifted;
    int   count;
    int   i;
    case (code)
      CccDirectGetbcr:    value = 48'(get_bcr);
      CccDirectGetdcr:    value = 48'(get_dcr);
      CccDirectGetmwl:    value = 48'(get_mwl);
      CccDirectGetstatus: value = 48'(get_status);
      CccDirectGetmrl:    value = 48'({get_mrl, IbiPayload});
      default:            value = get_pid;
    endcase
    case (code)
      CccDirectGetbcr, CccDirectGetdcr:    count = 1;
      CccDirectGetmwl, CccDirectGetstatus: count = 2;
      CccDirectGetmrl:                     count = 3;
      default:                             count = 6;
    endcase
    // Most significant byte first, T-bit high while more follow
    for (i = 0; i < count; i++) begin
      shifted = value >> (8 * (count - 1 - i));
      serve_tx(ReqTxByte, shifted[7:0], 1'b1);
      serve_tx(ReqTxBit, {7'd0, i != count - 1}, 1'b1);
    end
  endtask

  task automatic direct_ccc(input ccc_code_t code);
    logic   is_get;
    logic   ours;
    logic   rsvd;
    addr7_t addr;
    int     pick;
    is_get = (code >= CccDirectGetmwl);
    pick   = rand_below(4);
    if (pick == 0) addr = DynAddr;
    else if (pick == 1) addr = StaAddr;
    else if (pick == 2) addr = OtherAddr;
    else addr = RsvdAddr;
    rsvd = (addr == RsvdAddr);
    ours = (addr == DynAddr) || (addr == StaAddr);
    send_rstart();
    serve_rx(ReqRxByte, {addr, is_get});
    // ACK low in open drain, NACK high
    serve_tx(ReqTxBit, {7'd0, !(ours || rsvd)}, 1'b0);
    if (rsvd) want[4]++;
    else if (ours && is_get) read_data(code);
    else if (ours) write_data(code, addr == DynAddr);
  endtask

  task automatic run_ccc(input ccc_code_t code);
    send_ccc(code);
    serve_rx(ReqRxBit, 8'h00);
    if (code[7]) direct_ccc(code);
    else if (code == CccBcastRstdaa) want[2]++;
    else write_data(code, 1'b0);
    end_ccc();
  endtask

  // Pulse counters and request sanity
  always @(negedge clk) begin
    if (rst_n) begin
      assert ($onehot0(bus_req))
        else abort_run("more than one bus request active at the same time");
      if (set_mwl) seen[0]++;
      if (set_mrl) seen[1]++;
      if (rstdaa) seen[2]++;
      if (set_newda) begin
        seen[3]++;
        seen_newda = newda;
      end
      if (next_ccc) seen[4]++;
      if (done_fsm) seen[5]++;
    end
  end

  initial begin
    rst_n      <= 1'b0;
    ccc        <= '0;
    ccc_valid  <= 1'b0;
    bus_cond   <= '0;
    bus_rx     <= '0;
    tx_done    <= 1'b0;
    target     <= '{sta_addr: StaAddr, sta_valid: 1'b1, dyn_addr: DynAddr, dyn_valid: 1'b1};
    get_bcr    <= rand_byte();
    get_dcr    <= rand_byte();
    get_mwl    <= {rand_byte(), rand_byte()};
    get_mrl    <= {rand_byte(), rand_byte()};
    get_status <= {rand_byte(), rand_byte()};
    get_pid    <= {rand_byte(), rand_byte(), rand_byte(), rand_byte(), rand_byte(), rand_byte()};
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_equal("bus request", 48'(bus_req), 48'd0);
    compare_outputs();
    for (int n = 0; n < NumCcc; n++) begin
      run_ccc(codes[rand_below(16)]);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/ccc_pkg.sv
source/ccc_ctrl.sv
source/ccc_addr_match.sv
source/ccc_get_tx.sv
source/ccc_set_rx.sv
source/ccc_top.sv
dv/ccc_chk.sv
dv/tb_ccc.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -j 0 --top-module tb_ccc -f tb.f -o sim_tb_ccc &&
  ./obj_dir/sim_tb_ccc ||
  exit 1
